// File: mmc1_bus_pkg.sv
package mmc1_bus_pkg;

	////////////////////////////////////////////////////////////////////
	// bus widths
	////////////////////////////////////////////////////////////////////

	localparam int cpu_addr_w = 16;
	localparam int ppu_addr_w = 14;
	// 512K of PRG ROM
	localparam int prg_addr_w = 19;
	// 128K of CHR ROM or RAM
	localparam int chr_addr_w = 17;
	// 32K of battery SRAM, four 8K banks
	localparam int srm_addr_w = 15;
	localparam int sst_addr_w = 8;
	localparam int data_w     = 8;

	////////////////////////////////////////////////////////////////////
	// address and data types
	////////////////////////////////////////////////////////////////////

	// cpu side
	typedef logic [cpu_addr_w-1:0] cpu_addr_t;
	typedef logic [data_w-1:0]     byte_t;

	// ppu side
	typedef logic [ppu_addr_w-1:0] ppu_addr_t;

	// memories behind the mapper
	typedef logic [prg_addr_w-1:0] prg_addr_t;
	typedef logic [chr_addr_w-1:0] chr_addr_t;
	typedef logic [srm_addr_w-1:0] srm_addr_t;

	// save-state register space
	typedef logic [sst_addr_w-1:0] sst_addr_t;

endpackage

// File: mmc1_reg_pkg.sv
package mmc1_reg_pkg;

	////////////////////////////////////////////////////////////////////
	// mapper registers
	////////////////////////////////////////////////////////////////////

	localparam int reg_w = 5;

	typedef logic [reg_w-1:0] map_reg_t;

	// register select, taken from cpu address bits 14:13
	localparam logic [1:0] reg_ctrl = 2'd0;
	localparam logic [1:0] reg_chr0 = 2'd1;
	localparam logic [1:0] reg_chr1 = 2'd2;
	localparam logic [1:0] reg_prg  = 2'd3;

	// save-state address of the shift buffer, registers sit at 0 to 3
	localparam logic [7:0] sst_buff_addr = 8'd4;

	// control bits above the two mirroring bits
	localparam int ctrl_prg_slot = 2;
	localparam int ctrl_prg_mode = 3;
	localparam int ctrl_chr_mode = 4;

	// prg register bit 4 turns the SRAM off
	localparam int prg_ram_dis = 4;

	localparam map_reg_t ctrl_reset_value = 5'b11111;

	// marker bit walks down to bit 0 on the fourth shift
	localparam map_reg_t buff_empty = 5'b10000;

	////////////////////////////////////////////////////////////////////
	// chr bank word, two readings
	////////////////////////////////////////////////////////////////////

	// rom boards use the whole word as a 4K bank number
	// SNROM/SUROM style ram boards reuse the upper bits for prg and sram
	typedef union packed {
		map_reg_t rom_bank;
		struct packed {
			logic       prg_256k;
			logic [1:0] srm_bank;
			logic       unused;
			logic       chr_4k;
		} ram;
	} chr_bank_u;

endpackage

// File: mmc1_serial_port.sv
`timescale 1ns/1ps

module mmc1_serial_port
	import mmc1_bus_pkg::*;
	import mmc1_reg_pkg::*;
(
	input  logic      m2,
	input  logic      reg_rst,

	input  cpu_addr_t cpu_addr,
	input  byte_t     cpu_data,
	input  logic      cpu_rw,

	input  logic      sst_act,
	input  logic      sst_we,
	input  sst_addr_t sst_addr,
	input  byte_t     sst_dato,

	output map_reg_t  r_ctrl,
	output map_reg_t  r_chr0,
	output map_reg_t  r_chr1,
	output map_reg_t  r_prg,
	output byte_t     sst_di
);

	logic     wr_cycle;
	logic     wr_last;
	logic     reg_we;
	logic     serial_clear;
	logic     reg_load;
	logic     sst_reg_we;
	logic     sst_buff_we;
	map_reg_t shift_next;
	map_reg_t buff;
	map_reg_t map_regs [4];

	//////////////////////////////////////////////////////////////////////
	// write detection
	//////////////////////////////////////////////////////////////////////

	// any cpu write into 8000-ffff
	assign wr_cycle = cpu_addr[15] & ~cpu_rw;

	// second write of a back-to-back pair is dropped, as on the real chip
	assign reg_we       = wr_cycle & ~wr_last & ~sst_act;
	assign serial_clear = reg_we & cpu_data[7];

	// fifth write: marker has reached bit 0
	assign reg_load   = reg_we & ~cpu_data[7] & buff[0];
	assign shift_next = {cpu_data[0], buff[4:1]};

	always_ff @(posedge m2)
	begin
		if (reg_rst)
			wr_last <= 1'b0;
		else
			wr_last <= wr_cycle;
	end

	//////////////////////////////////////////////////////////////////////
	// shift buffer and register file
	//////////////////////////////////////////////////////////////////////

	assign sst_reg_we  = sst_we & (sst_addr[7:2] == 6'd0);
	assign sst_buff_we = sst_we & (sst_addr == sst_buff_addr);

	always_ff @(posedge m2)
	begin
		if (reg_rst)
		begin
			map_regs[reg_ctrl]              <= ctrl_reset_value;
			map_regs[reg_prg][prg_ram_dis]  <= 1'b0;
			buff                            <= buff_empty;
		end
		else if (sst_act)
		begin
			// restore path, cpu writes are ignored meanwhile
			if (sst_reg_we)
				map_regs[sst_addr[1:0]] <= sst_dato[4:0];
			if (sst_buff_we)
				buff <= sst_dato[4:0];
		end
		else if (serial_clear)
		begin
			buff <= buff_empty;
			// back to fixed-last 16K prg
			map_regs[reg_ctrl][ctrl_prg_mode:ctrl_prg_slot] <= 2'b11;
		end
		else if (reg_load)
		begin
			map_regs[cpu_addr[14:13]] <= shift_next;
			buff                      <= buff_empty;
		end
		else if (reg_we)
		begin
			buff <= shift_next;
		end
	end

	assign r_ctrl = map_regs[reg_ctrl];
	assign r_chr0 = map_regs[reg_chr0];
	assign r_chr1 = map_regs[reg_chr1];
	assign r_prg  = map_regs[reg_prg];

	// save-state readback
	always_comb
	begin
		if (sst_addr[7:2] == 6'd0)
			sst_di = {3'b000, map_regs[sst_addr[1:0]]};
		else if (sst_addr == sst_buff_addr)
			sst_di = {3'b000, buff};
		else
			sst_di = 8'hff;
	end

	//////////////////////////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////////////////////////

	// marker bit never falls out of the buffer across a shift sequence
	a_buff_marker: assert property (@(posedge m2) disable iff (reg_rst || sst_act)
		buff != '0);

	// edge filter keeps loads at least one cycle apart
	a_load_spacing: assert property (@(posedge m2) disable iff (reg_rst)
		reg_load |=> !reg_load);

endmodule

// File: mmc1_bank_map.sv
`timescale 1ns/1ps

module mmc1_bank_map
	import mmc1_bus_pkg::*;
	import mmc1_reg_pkg::*;
#(
	parameter bit prg_fixed_32k = 1'b0,
	parameter bit ram_always_on = 1'b0,
	parameter bit chr_ram       = 1'b0
)
(
	input  map_reg_t  r_ctrl,
	input  map_reg_t  r_chr0,
	input  map_reg_t  r_chr1,
	input  map_reg_t  r_prg,

	input  cpu_addr_t cpu_addr,
	input  logic      cpu_rw,
	input  ppu_addr_t ppu_addr,
	input  logic      ppu_oe_n,
	input  logic      ppu_we_n,
	input  byte_t     prg_do,
	input  byte_t     srm_do,

	output prg_addr_t prg_addr,
	output logic      prg_ce,
	output logic      prg_oe,
	output logic      prg_we,

	output chr_addr_t chr_addr,
	output logic      chr_ce,
	output logic      chr_oe,
	output logic      chr_we,

	output srm_addr_t srm_addr,
	output logic      srm_ce,
	output logic      srm_oe,
	output logic      srm_we,

	output logic      ciram_a10,
	output logic      ciram_ce,

	output logic      cpu_oe,
	output byte_t     cpu_do
);

	logic       prg_mode;
	logic       chr_mode;
	logic       ram_on;
	logic [3:0] prg_bank;
	logic [1:0] srm_bank;
	chr_bank_u  chr_bank;

	// prg_mode 0 is 32K, chr_mode 0 is 8K
	assign prg_mode = r_ctrl[ctrl_prg_mode];
	assign chr_mode = r_ctrl[ctrl_chr_mode];

	//////////////////////////////////////////////////////////////////////
	// bank selection
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		if (!prg_mode)
			prg_bank = {r_prg[3:1], cpu_addr[14]};
		else if (r_ctrl[ctrl_prg_slot] != cpu_addr[14])
			prg_bank = r_prg[3:0];
		else if (cpu_addr[14])
			// fixed last bank at c000
			prg_bank = 4'hf;
		else
			// fixed first bank at 8000
			prg_bank = 4'h0;
	end

	always_comb
	begin
		if (!chr_mode)
			chr_bank.rom_bank = {r_chr0[4:1], ppu_addr[12]};
		else if (ppu_addr[12])
			chr_bank.rom_bank = r_chr1;
		else
			chr_bank.rom_bank = r_chr0;
	end

	// sram bank lines only exist on chr ram boards
	assign srm_bank = chr_ram ? chr_bank.ram.srm_bank : 2'b00;
	assign ram_on   = ~r_prg[prg_ram_dis] | ram_always_on;

	//////////////////////////////////////////////////////////////////////
	// memory pins
	//////////////////////////////////////////////////////////////////////

	// prg rom, 8000-ffff
	assign prg_ce          = cpu_addr[15];
	assign prg_oe          = cpu_rw;
	assign prg_we          = 1'b0;
	assign prg_addr[13:0]  = cpu_addr[13:0];
	assign prg_addr[14]    = prg_fixed_32k ? cpu_addr[14] : prg_bank[0];
	assign prg_addr[18:15] = {chr_bank.ram.prg_256k, prg_bank[3:1]};

	// sram, 6000-7fff
	assign srm_ce          = (cpu_addr[15:13] == 3'b011) & ram_on;
	assign srm_oe          = cpu_rw;
	assign srm_we          = srm_ce & ~cpu_rw;
	assign srm_addr[12:0]  = cpu_addr[12:0];
	assign srm_addr[14:13] = srm_bank;

	// pattern tables, 0000-1fff on the ppu bus
	assign chr_ce          = ~ppu_addr[13];
	assign chr_oe          = ~ppu_oe_n;
	assign chr_we          = chr_ram & chr_ce & ~ppu_we_n;
	assign chr_addr[11:0]  = ppu_addr[11:0];
	assign chr_addr[16:12] = chr_ram ? {4'b0000, chr_bank.ram.chr_4k} : chr_bank.rom_bank;

	//////////////////////////////////////////////////////////////////////
	// mirroring and cpu read data
	//////////////////////////////////////////////////////////////////////

	// 0 and 1 single screen, 2 vertical on A10, 3 horizontal on A11
	always_comb
	begin
		case (r_ctrl[1:0])
			2'd0:    ciram_a10 = 1'b0;
			2'd1:    ciram_a10 = 1'b1;
			2'd2:    ciram_a10 = ppu_addr[10];
			default: ciram_a10 = ppu_addr[11];
		endcase
	end

	assign ciram_ce = ~ppu_addr[13];

	assign cpu_oe = (srm_ce & srm_oe) | (prg_ce & prg_oe);
	assign cpu_do = srm_ce ? srm_do : prg_do;

	// address windows must not overlap
	always_comb
	begin
		a_one_cpu_target: assert (!(srm_ce && prg_ce))
			else $error("sram and prg rom selected together");
	end

endmodule

// File: mmc1_mapper.sv
`timescale 1ns/1ps

module mmc1_mapper
	import mmc1_bus_pkg::*;
	import mmc1_reg_pkg::*;
#(
	parameter bit prg_fixed_32k = 1'b0,
	parameter bit ram_always_on = 1'b0,
	parameter bit chr_ram       = 1'b0
)
(
	input  logic      m2,
	input  logic      reg_rst,

	// cpu bus
	input  cpu_addr_t cpu_addr,
	input  byte_t     cpu_data,
	input  logic      cpu_rw,
	input  byte_t     prg_do,
	input  byte_t     srm_do,
	output logic      cpu_oe,
	output byte_t     cpu_do,

	// ppu bus
	input  ppu_addr_t ppu_addr,
	input  logic      ppu_oe_n,
	input  logic      ppu_we_n,

	// save state
	input  logic      sst_act,
	input  logic      sst_we,
	input  sst_addr_t sst_addr,
	input  byte_t     sst_dato,
	output byte_t     sst_di,

	// memories and nametables
	output prg_addr_t prg_addr,
	output logic      prg_ce,
	output logic      prg_oe,
	output logic      prg_we,
	output chr_addr_t chr_addr,
	output logic      chr_ce,
	output logic      chr_oe,
	output logic      chr_we,
	output srm_addr_t srm_addr,
	output logic      srm_ce,
	output logic      srm_oe,
	output logic      srm_we,
	output logic      ciram_a10,
	output logic      ciram_ce
);

	map_reg_t r_ctrl;
	map_reg_t r_chr0;
	map_reg_t r_chr1;
	map_reg_t r_prg;

	mmc1_serial_port mmc1_serial_port_inst (
		.m2       (m2),
		.reg_rst  (reg_rst),
		.cpu_addr (cpu_addr),
		.cpu_data (cpu_data),
		.cpu_rw   (cpu_rw),
		.sst_act  (sst_act),
		.sst_we   (sst_we),
		.sst_addr (sst_addr),
		.sst_dato (sst_dato),
		.r_ctrl   (r_ctrl),
		.r_chr0   (r_chr0),
		.r_chr1   (r_chr1),
		.r_prg    (r_prg),
		.sst_di   (sst_di)
	);

	mmc1_bank_map #(
		.prg_fixed_32k (prg_fixed_32k),
		.ram_always_on (ram_always_on),
		.chr_ram       (chr_ram)
	) mmc1_bank_map_inst (
		.r_ctrl    (r_ctrl),
		.r_chr0    (r_chr0),
		.r_chr1    (r_chr1),
		.r_prg     (r_prg),
		.cpu_addr  (cpu_addr),
		.cpu_rw    (cpu_rw),
		.ppu_addr  (ppu_addr),
		.ppu_oe_n  (ppu_oe_n),
		.ppu_we_n  (ppu_we_n),
		.prg_do    (prg_do),
		.srm_do    (srm_do),
		.prg_addr  (prg_addr),
		.prg_ce    (prg_ce),
		.prg_oe    (prg_oe),
		.prg_we    (prg_we),
		.chr_addr  (chr_addr),
		.chr_ce    (chr_ce),
		.chr_oe    (chr_oe),
		.chr_we    (chr_we),
		.srm_addr  (srm_addr),
		.srm_ce    (srm_ce),
		.srm_oe    (srm_oe),
		.srm_we    (srm_we),
		.ciram_a10 (ciram_a10),
		.ciram_ce  (ciram_ce),
		.cpu_oe    (cpu_oe),
		.cpu_do    (cpu_do)
	);

endmodule

// File: mmc1_tb.sv
`timescale 1ns/1ps

module mmc1_tb
	import mmc1_bus_pkg::*;
();

	// dut inputs
	logic      m2       = 1'b0;
	logic      reg_rst  = 1'b1;
	cpu_addr_t cpu_addr = '0;
	byte_t     cpu_data = '0;
	logic      cpu_rw   = 1'b1;
	byte_t     prg_do   = 8'ha5;
	byte_t     srm_do   = 8'h5a;
	ppu_addr_t ppu_addr = '0;
	logic      ppu_oe_n = 1'b1;
	logic      ppu_we_n = 1'b1;
	logic      sst_act  = 1'b0;
	logic      sst_we   = 1'b0;
	sst_addr_t sst_addr = '0;
	byte_t     sst_dato = '0;

	// dut outputs
	logic      cpu_oe;
	byte_t     cpu_do;
	byte_t     sst_di;
	prg_addr_t prg_addr;
	chr_addr_t chr_addr;
	srm_addr_t srm_addr;
	logic      prg_ce;
	logic      prg_oe;
	logic      prg_we;
	logic      chr_ce;
	logic      chr_oe;
	logic      chr_we;
	logic      srm_ce;
	logic      srm_oe;
	logic      srm_we;
	logic      ciram_a10;
	logic      ciram_ce;

	logic        stim_ready = 1'b0;
	logic [31:0] op_q[$];
	logic [31:0] addr_q[$];
	logic [31:0] data_q[$];
	logic [31:0] exp_q[$];
	logic [31:0] aux_q[$];

	mmc1_mapper #(
		.prg_fixed_32k (1'b0),
		.ram_always_on (1'b0),
		.chr_ram       (1'b1)
	) mmc1_mapper_inst (.*);

	initial
	begin
		forever
			#10 m2 = ~m2;
	end

	//////////////////////////////////////////////////////////////////////
	// reporting and compares
	//////////////////////////////////////////////////////////////////////

	task automatic stop_run(input string why);
		$display("%s", why);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_pin(input string name, input logic got, input logic exp);
		if (got !== exp)
			stop_run($sformatf("Fail at time %0t: %s %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_data(input byte_t exp);
		if (cpu_do !== exp)
			stop_run($sformatf("Fail at time %0t: cpu_do %h, expected %h",
				$time, cpu_do, exp));
	endtask

	task automatic check_prg(input prg_addr_t exp);
		if (prg_addr !== exp)
			stop_run($sformatf("Fail at time %0t: prg_addr %h, expected %h",
				$time, prg_addr, exp));
		// rom read at 8000-ffff
		check_pin("prg_ce", prg_ce, 1'b1);
		check_pin("prg_oe", prg_oe, 1'b1);
		check_pin("prg_we", prg_we, 1'b0);
		check_pin("srm_ce", srm_ce, 1'b0);
		check_pin("cpu_oe", cpu_oe, 1'b1);
		check_data(prg_do);
	endtask

	task automatic check_chr(input chr_addr_t exp, input logic exp_a10,
		input logic exp_ce);
		if (chr_addr !== exp)
			stop_run($sformatf("Fail at time %0t: chr_addr %h, expected %h",
				$time, chr_addr, exp));
		if (ciram_a10 !== exp_a10)
			stop_run($sformatf("Fail at time %0t: ciram_a10 %b, expected %b",
				$time, ciram_a10, exp_a10));
		check_pin("chr_ce", chr_ce, exp_ce);
		check_pin("ciram_ce", ciram_ce, exp_ce);
		check_pin("chr_oe", chr_oe, 1'b1);
		check_pin("chr_we", chr_we, 1'b0);
	endtask

	task automatic check_srm(input srm_addr_t exp, input logic exp_ce);
		if (srm_addr !== exp)
			stop_run($sformatf("Fail at time %0t: srm_addr %h, expected %h",
				$time, srm_addr, exp));
		if (srm_ce !== exp_ce)
			stop_run($sformatf("Fail at time %0t: srm_ce %b, expected %b",
				$time, srm_ce, exp_ce));
		// 6000-7fff is outside the prg window
		check_pin("prg_ce", prg_ce, 1'b0);
		check_pin("srm_oe", srm_oe, 1'b1);
		check_pin("srm_we", srm_we, 1'b0);
		check_pin("cpu_oe", cpu_oe, exp_ce);
		if (exp_ce)
			check_data(srm_do);
		else
			check_data(prg_do);
	endtask

	task automatic check_sst(input byte_t exp);
		if (sst_di !== exp)
			stop_run($sformatf("Fail at time %0t: sst_di %h, expected %h",
				$time, sst_di, exp));
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	task automatic read_stim();
		int          fd;
		int          n;
		string       line;
		logic [31:0] f_op;
		logic [31:0] f_addr;
		logic [31:0] f_data;
		logic [31:0] f_exp;
		logic [31:0] f_aux;
		fd = $fopen("mmc1_stim.txt", "r");
		if (fd == 0)
			stop_run("could not open mmc1_stim.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h %h", f_op, f_addr, f_data, f_exp, f_aux);
			if (n == 5)
			begin
				op_q.push_back(f_op);
				addr_q.push_back(f_addr);
				data_q.push_back(f_data);
				exp_q.push_back(f_exp);
				aux_q.push_back(f_aux);
			end
		end
		$fclose(fd);
		if (op_q.size() == 0)
			stop_run("no operations found in mmc1_stim.txt");
	endtask

	// bus goes idle a little after the edge
	task automatic next_cycle();
		@(posedge m2);
		#2;
		cpu_addr = '0;
		cpu_data = '0;
		cpu_rw   = 1'b1;
		sst_act  = 1'b0;
		sst_we   = 1'b0;
		sst_addr = '0;
		sst_dato = '0;
		// A12 held low so chr0 feeds the 256K and sram bank bits
		ppu_addr = ppu_addr_t'($urandom) & 14'h2fff;
		ppu_oe_n = 1'b1;
		ppu_we_n = 1'b1;
	endtask

	task automatic run_op(input logic [31:0] op, addr, data, exp, aux);
		next_cycle();
		case (op)
			0: ;
			1, 8:
			begin
				cpu_addr = cpu_addr_t'(addr);
				cpu_data = byte_t'(data);
				cpu_rw   = 1'b0;
				sst_act  = (op == 8);
			end
			2:
			begin
				// five serial writes, lsb first, idle after each
				for (int b = 0; b < 5; b++)
				begin
					cpu_addr = cpu_addr_t'(addr);
					cpu_data = {7'b0, data[b]};
					cpu_rw   = 1'b0;
					next_cycle();
					if (b < 4)
						next_cycle();
				end
			end
			3:
			begin
				cpu_addr = cpu_addr_t'(addr);
				#17;
				check_prg(prg_addr_t'(exp));
			end
			4:
			begin
				cpu_addr = cpu_addr_t'(addr);
				#17;
				check_srm(srm_addr_t'(exp), aux[0]);
			end
			5:
			begin
				ppu_addr = ppu_addr_t'(addr);
				ppu_oe_n = 1'b0;
				#17;
				check_chr(chr_addr_t'(exp), aux[0], ~addr[13]);
			end
			6:
			begin
				sst_act  = 1'b1;
				sst_we   = 1'b1;
				sst_addr = sst_addr_t'(addr);
				sst_dato = byte_t'(data);
			end
			7:
			begin
				sst_act  = 1'b1;
				sst_addr = sst_addr_t'(addr);
				#17;
				check_sst(byte_t'(exp));
			end
			default:
				stop_run($sformatf("unknown operation %0h in stimulus file", op));
		endcase
	endtask

	initial
	begin
		void'($urandom(3));
		read_stim();
		stim_ready = 1'b1;
		repeat (8) @(posedge m2);
		#2;
		reg_rst = 1'b0;
		for (int i = 0; i < op_q.size(); i++)
			run_op(op_q[i], addr_q[i], data_q[i], exp_q[i], aux_q[i]);
		@(posedge m2);
		$display(">>> PASS");
		$finish;
	end

	// watchdog
	initial
	begin
		int limit;
		wait (stim_ready);
		limit = op_q.size() * 4 + 100;
		repeat (limit) @(posedge m2);
		stop_run($sformatf("timeout, stimulus still running after %0d cycles", limit));
	end

endmodule

// File: mmc1_stim.txt
# columns: op addr data expect aux, all hex
# op 0 idle, 1 write, 2 serial load, 3 prg read, 4 sram read (aux srm_ce), 5 ppu (aux ciram_a10), 6 sst write, 7 sst read, 8 write with sst active
# reset state, chr0 loaded first so the 256K and sram bits are known
2 a000 16 00000 0
3 c123 00 7c123 0
4 6010 00 02010 1
5 0a45 00 00a45 1
# chr1 and prg banks in 4K chr mode
2 c000 0b 00000 0
5 1456 00 01456 0
2 e000 05 00000 0
3 8abc 00 54abc 0
# 32K prg, 8K chr, single screen 0
2 8000 00 00000 0
3 8001 00 50001 0
3 c002 00 54002 0
5 1400 00 01400 0
2 8000 01 00000 0
5 0000 00 00000 1
# one partial bit, then a serial clear back to fixed-last 16K
1 8000 01 00000 0
0 0000 00 00000 0
1 8000 80 00000 0
3 c010 00 7c010 0
# back-to-back write dropped, control ends at 1a
1 8000 00 00000 0
0 0000 00 00000 0
1 8000 01 00000 0
1 8000 00 00000 0
0 0000 00 00000 0
1 8000 00 00000 0
0 0000 00 00000 0
1 8000 01 00000 0
0 0000 00 00000 0
1 8000 01 00000 0
3 8123 00 40123 0
3 c456 00 54456 0
5 0400 00 00400 1
# sram off by prg bit 4
2 e000 15 00000 0
4 6000 00 02000 0
# save state
6 0000 13 00000 0
6 0004 08 00000 0
8 a000 80 00000 0
7 0000 00 00013 0
7 0004 00 00008 0
7 0001 00 00016 0
7 0007 00 000ff 0

// File: verilog.f
mmc1_bus_pkg.sv
mmc1_reg_pkg.sv
mmc1_serial_port.sv
mmc1_bank_map.sv
mmc1_mapper.sv
mmc1_tb.sv

// File: Makefile
TOOL   = verilator
FLAGS  = --binary --timing --assert
TOP    = mmc1_tb
FLIST  = verilog.f
OBJDIR = obj_dir
LOG    = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
